//--- src.f
hdl/cpuPkg.sv
hdl/instructionDecoder.sv
hdl/registerFile.sv
hdl/operandForward.sv
hdl/arithmeticLogicUnit.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/cpuCore.sv
testbench/cpuCoreTb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - hdl/cpuPkg.sv
  - hdl/instructionDecoder.sv
  - hdl/registerFile.sv
  - hdl/operandForward.sv
  - hdl/arithmeticLogicUnit.sv
  - hdl/decodeStage.sv
  - hdl/executeStage.sv
  - hdl/cpuCore.sv
  - target: test
    files:
      - testbench/cpuCoreTb.sv

//--- testbench/cpuCoreTb.sv
`timescale 1ns/1ps

module cpuCoreTb import cpuPkg::*; ();

    // About twice the total length of the tests
    localparam int cycleLimit = 1500;

    logic clk;
    logic reset;
    logic instValid;
    wordT instWord;
    regWriteT wbReport;

    int cycle = 0;
    int errors = 0;
    int checks = 0;
    int testsRun = 0;
    int testErrStart;
    int lastDue;
    string currentTest = "reset";
    logic [31:0] rngState = 32'h4563;
    wordT refRegs [32] = '{default: '0};
    int dueQ [$];
    regWriteT expQ [$];
    regWriteT monitorExpected;
    logic [5:0] rFuncts [11] = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu,
                                 fnSll, fnSrl, fnSra};
    logic [5:0] iOps [7] = '{opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui};

    cpuCore cpuCore_i (
        .clk(clk),
        .reset(reset),
        .instValid(instValid),
        .instWord(instWord),
        .wbReport(wbReport)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Debug port must match the queue head when due and stay idle otherwise
    always @(negedge clk) begin
        if (cycle > 0) begin
            monitorExpected = '0;
            if (dueQ.size() > 0 && dueQ[0] == cycle) begin
                monitorExpected = expQ.pop_front();
                dueQ.delete(0);
            end
            compareRegWrite(currentTest, monitorExpected, wbReport);
        end
    end

    function automatic logic [31:0] nextRand();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic wordT rType(logic [5:0] funct, regAddrT rd, regAddrT rs, regAddrT rt,
                                   logic [4:0] shamt);
        return {opSpecial, rs, rt, rd, shamt, funct};
    endfunction

    function automatic wordT iType(logic [5:0] op, regAddrT rt, regAddrT rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic compareRegWrite(string name, regWriteT expected, regWriteT actual);
        checks++;
        if (actual.valid !== expected.valid || (expected.valid &&
                (actual.num !== expected.num || actual.data !== expected.data))) begin
            errors++;
            $display("ERR %s: expected v=%b r%0d=%h, actual v=%b r%0d=%h", name,
                     expected.valid, expected.num, expected.data,
                     actual.valid, actual.num, actual.data);
        end
    endtask

    task automatic compareWord(string name, wordT expected, wordT actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic sendInst(wordT word, regAddrT dest, wordT result);
        @(posedge clk);
        #1;
        instValid = 1'b1;
        instWord = word;
        lastDue = cycle + 3;
        if (dest != '0) begin
            refRegs[dest] = result;
            dueQ.push_back(lastDue);
            expQ.push_back({1'b1, dest, result});
        end
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            instValid = 1'b0;
            instWord = nextRand();
        end
    endtask

    // Reference model evaluated in program order
    task automatic issueR(logic [5:0] funct, regAddrT rd, regAddrT rs, regAddrT rt,
                          logic [4:0] shamt);
        wordT a;
        wordT b;
        wordT r;
        a = refRegs[rs];
        b = refRegs[rt];
        case (funct)
            fnAddu: r = a + b;
            fnSubu: r = a - b;
            fnAnd: r = a & b;
            fnOr: r = a | b;
            fnXor: r = a ^ b;
            fnNor: r = ~(a | b);
            fnSlt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            fnSltu: r = (a < b) ? 32'd1 : 32'd0;
            fnSll: r = b << shamt;
            fnSrl: r = b >> shamt;
            fnSra: r = (b >> shamt) | (b[31] ? ~(32'hFFFF_FFFF >> shamt) : 32'h0);
            default: r = '0;
        endcase
        sendInst(rType(funct, rd, rs, rt, shamt), rd, r);
    endtask

    task automatic issueI(logic [5:0] op, regAddrT rt, regAddrT rs, logic [15:0] imm);
        wordT a;
        wordT sext;
        wordT zext;
        wordT r;
        a = refRegs[rs];
        sext = {{16{imm[15]}}, imm};
        zext = {16'h0, imm};
        case (op)
            opAddiu: r = a + sext;
            opSlti: r = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            opSltiu: r = (a < sext) ? 32'd1 : 32'd0;
            opAndi: r = a & zext;
            opOri: r = a | zext;
            opXori: r = a ^ zext;
            opLui: r = {imm, 16'h0};
            default: r = '0;
        endcase
        sendInst(iType(op, rt, rs, imm), rt, r);
    endtask

    task automatic startTest(string name);
        currentTest = name;
        testErrStart = errors;
    endtask

    task automatic finishTest();
        idle(1);
        while (dueQ.size() > 0) begin
            idle(1);
        end
        idle(3);
        testsRun++;
        $display("%s: done with %0d errors", currentTest, errors - testErrStart);
    endtask

    task automatic checkReset();
        startTest("reset");
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        finishTest();
    endtask

    task automatic eachOperation();
        startTest("each operation");
        issueI(opLui, 1, 0, 16'h8765);
        idle(3);
        issueI(opOri, 1, 1, 16'h4321);
        idle(3);
        issueI(opLui, 2, 0, 16'h1234);
        idle(3);
        issueI(opOri, 2, 2, 16'h5678);
        idle(3);
        issueI(opAddiu, 3, 0, 16'hFFFE);
        idle(3);
        // Shifts act on the negative r1
        for (int i = 0; i < 11; i++) begin
            issueR(rFuncts[i], regAddrT'(4 + i), 2, 1, 5'd4);
            idle(3);
        end
        // Positive r2 against -1 splits signed from unsigned
        for (int i = 0; i < 7; i++) begin
            issueI(iOps[i], regAddrT'(15 + i), (i < 3) ? 5'd2 : 5'd1,
                   (i < 3) ? 16'hFFFF : 16'hF0F0);
            idle(3);
        end
        finishTest();
    endtask

    task automatic forwardChains();
        startTest("forwarding");
        issueI(opAddiu, 1, 0, 16'd5);
        issueR(fnAddu, 2, 1, 1, 5'd0);
        issueR(fnAddu, 3, 2, 1, 5'd0);
        issueR(fnSubu, 4, 3, 2, 5'd0);
        issueR(fnSll, 5, 0, 4, 5'd3);
        issueR(fnSltu, 6, 5, 4, 5'd0);
        // One unrelated instruction between producer and consumer
        issueI(opAddiu, 7, 5, 16'h0007);
        issueI(opOri, 20, 0, 16'h0055);
        issueR(fnXor, 8, 7, 5, 5'd0);
        issueI(opAndi, 21, 0, 16'h0001);
        issueR(fnAddu, 9, 8, 7, 5'd0);
        issueI(opXori, 22, 20, 16'h00FF);
        issueR(fnNor, 10, 9, 8, 5'd0);
        issueR(fnAddu, 11, 10, 9, 5'd0);
        // r12 pending in both later stages at once
        issueI(opAddiu, 12, 0, 16'd1);
        issueI(opAddiu, 12, 12, 16'd2);
        issueR(fnAddu, 13, 12, 12, 5'd0);
        finishTest();
    endtask

    task automatic registerZero();
        int zeroDue;
        startTest("register zero");
        issueI(opOri, 0, 1, 16'h1234);
        issueR(fnAddu, 14, 0, 0, 5'd0);
        zeroDue = lastDue;
        idle(1);
        while (cycle < zeroDue) begin
            @(negedge clk);
        end
        compareWord(currentTest, 32'h0, wbReport.data);
        issueR(fnOr, 0, 1, 2, 5'd0);
        issueR(fnAddu, 15, 0, 3, 5'd0);
        issueR(fnSubu, 16, 15, 0, 5'd0);
        finishTest();
    endtask

    task automatic unknownAndIdle();
        startTest("unknown and idle");
        issueI(opAddiu, 16, 0, 16'h0011);
        sendInst(iType(6'h23, 2, 1, 16'h0004), '0, '0);
        idle(1);
        issueI(opAddiu, 17, 16, 16'h0001);
        sendInst(rType(6'h18, 9, 16, 17, 5'd0), '0, '0);
        sendInst(iType(6'h04, 17, 16, 16'h0003), '0, '0);
        issueR(fnAddu, 18, 17, 16, 5'd0);
        idle(2);
        issueR(fnSubu, 19, 18, 17, 5'd0);
        sendInst(32'hFFFF_FFFF, '0, '0);
        issueR(fnSlt, 23, 16, 19, 5'd0);
        finishTest();
    endtask

    task automatic randomStream();
        logic [31:0] r;
        logic [31:0] s;
        startTest("random stream");
        for (int n = 0; n < 200; n++) begin
            r = nextRand();
            s = nextRand();
            // Eight registers keep dependencies close together
            if (r % 18 < 11) begin
                issueR(rFuncts[r % 18], {2'b0, s[2:0]}, {2'b0, s[5:3]}, {2'b0, s[8:6]},
                       s[13:9]);
            end else begin
                issueI(iOps[r % 18 - 11], {2'b0, s[2:0]}, {2'b0, s[5:3]}, s[31:16]);
            end
            idle(nextRand() % 3);
        end
        finishTest();
    endtask

    initial begin
        reset = 1'b1;
        instValid = 1'b0;
        instWord = '0;
        checkReset();
        eachOperation();
        forwardChains();
        registerZero();
        unknownAndIdle();
        randomStream();
        $display("Summary: %0d tests, %0d checks, %0d errors", testsRun, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- hdl/cpuCore.sv
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; (
    input logic clk,
    input logic reset,
    input logic instValid,
    input wordT instWord,
    output regWriteT wbReport
);

    logic issueValid;
    issueT issue;
    regWriteT exForward;
    regWriteT wbForward;

    decodeStage decodeStage_i (
        .clk(clk),
        .reset(reset),
        .instValid(instValid),
        .instWord(instWord),
        .exForward(exForward),
        .wbForward(wbForward),
        .issueValid(issueValid),
        .issue(issue)
    );

    executeStage executeStage_i (
        .clk(clk),
        .reset(reset),
        .issueValid(issueValid),
        .issue(issue),
        .exForward(exForward),
        .wbForward(wbForward)
    );

    // Debug port sees exactly what the register file writes
    assign wbReport = wbForward;

endmodule

//--- hdl/executeStage.sv
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
    input logic clk,
    input logic reset,
    input logic issueValid,
    input issueT issue,
    output regWriteT exForward,
    output regWriteT wbForward
);

    logic exValid;
    issueT exIssue;
    wordT aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            exValid <= 1'b0;
        end else begin
            exValid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        exIssue <= issue;
    end

    arithmeticLogicUnit alu_i (
        .aluOp(exIssue.aluOp),
        .a(exIssue.operandA),
        .b(exIssue.operandB),
        .result(aluResult)
    );

    // Nothing to write or forward for r0
    assign exForward.valid = exValid && exIssue.dest != '0;
    assign exForward.num = exIssue.dest;
    assign exForward.data = aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbForward.valid <= 1'b0;
        end else begin
            wbForward.valid <= exForward.valid;
        end
    end

    always_ff @(posedge clk) begin
        wbForward.num <= exForward.num;
        wbForward.data <= exForward.data;
    end

    // Decode drops unknown encodings before issue
    assert property (@(posedge clk) disable iff (reset) issueValid |-> issue.aluOp != aluNone);

endmodule

//--- hdl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; (
    input logic clk,
    input logic reset,
    input logic instValid,
    input wordT instWord,
    input regWriteT exForward,
    input regWriteT wbForward,
    output logic issueValid,
    output issueT issue
);

    logic heldValid;
    wordT heldWord;
    decodedT decoded;
    wordT regData1;
    wordT regData2;
    wordT source1;
    wordT source2;

    always_ff @(posedge clk) begin
        if (reset) begin
            heldValid <= 1'b0;
        end else begin
            heldValid <= instValid;
        end
    end

    always_ff @(posedge clk) begin
        heldWord <= instWord;
    end

    instructionDecoder decoder_i (
        .instWord(heldWord),
        .decoded(decoded)
    );

    // Writeback entry doubles as the write port
    registerFile registerFile_i (
        .clk(clk),
        .reset(reset),
        .readAddr1(decoded.src1),
        .readAddr2(decoded.src2),
        .readData1(regData1),
        .readData2(regData2),
        .write(wbForward)
    );

    operandForward forward1_i (
        .request(decoded.src1),
        .original(regData1),
        .exForward(exForward),
        .wbForward(wbForward),
        .value(source1)
    );

    operandForward forward2_i (
        .request(decoded.src2),
        .original(regData2),
        .exForward(exForward),
        .wbForward(wbForward),
        .value(source2)
    );

    // Unknown encodings drop out here
    assign issueValid = heldValid && decoded.aluOp != aluNone;
    assign issue.aluOp = decoded.aluOp;
    assign issue.operandA = source1;
    assign issue.operandB = decoded.useImm ? decoded.immediate : source2;
    assign issue.dest = decoded.dest;

    assert property (@(posedge clk) disable iff (reset) !$isunknown(instValid));

endmodule

//--- hdl/arithmeticLogicUnit.sv
`timescale 1ns/1ps

module arithmeticLogicUnit import cpuPkg::*; (
    input aluOpT aluOp,
    input wordT a,
    input wordT b,
    output wordT result
);

    logic [4:0] shiftAmount;

    assign shiftAmount = b[4:0];

    always_comb begin
        case (aluOp)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluAnd: result = a & b;
            aluOr: result = a | b;
            aluXor: result = a ^ b;
            aluNor: result = ~(a | b);
            aluSlt: result = {31'b0, $signed(a) < $signed(b)};
            aluSltu: result = {31'b0, a < b};
            aluSll: result = a << shiftAmount;
            aluSrl: result = a >> shiftAmount;
            aluSra: result = $signed(a) >>> shiftAmount;
            aluLui: result = {b[15:0], 16'b0};
            default: result = '0;
        endcase
    end

endmodule

//--- hdl/operandForward.sv
`timescale 1ns/1ps

module operandForward import cpuPkg::*; (
    input regAddrT request,
    input wordT original,
    input regWriteT exForward,
    input regWriteT wbForward,
    output wordT value
);

    always_comb begin
        if (request == '0) begin
            value = '0;
        end else if (exForward.valid && exForward.num == request) begin
            // Newest result wins
            value = exForward.data;
        end else if (wbForward.valid && wbForward.num == request) begin
            value = wbForward.data;
        end else begin
            value = original;
        end
    end

endmodule

//--- hdl/registerFile.sv
`timescale 1ns/1ps

module registerFile import cpuPkg::*; (
    input logic clk,
    input logic reset,
    input regAddrT readAddr1,
    input regAddrT readAddr2,
    output wordT readData1,
    output wordT readData2,
    input regWriteT write
);

    wordT regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write.valid && write.num != '0) begin
            regs[write.num] <= write.data;
        end
    end

    assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

    // Execute stage filters out writes to r0 before they get here
    assert property (@(posedge clk) disable iff (reset) write.valid |-> write.num != '0);

endmodule

//--- hdl/instructionDecoder.sv
`timescale 1ns/1ps

module instructionDecoder import cpuPkg::*; (
    input wordT instWord,
    output decodedT decoded
);

    logic [5:0] opcode;
    logic [5:0] funct;
    regAddrT rs;
    regAddrT rt;
    regAddrT rd;
    logic [4:0] shamt;
    wordT signExt;
    wordT zeroExt;

    assign opcode = instWord[31:26];
    assign rs = instWord[25:21];
    assign rt = instWord[20:16];
    assign rd = instWord[15:11];
    assign shamt = instWord[10:6];
    assign funct = instWord[5:0];
    assign signExt = {{16{instWord[15]}}, instWord[15:0]};
    assign zeroExt = {16'b0, instWord[15:0]};

    always_comb begin
        decoded = '0;
        decoded.aluOp = aluNone;
        case (opcode)
            opSpecial: begin
                decoded.src1 = rs;
                decoded.src2 = rt;
                decoded.dest = rd;
                case (funct)
                    fnAddu: decoded.aluOp = aluAdd;
                    fnSubu: decoded.aluOp = aluSub;
                    fnAnd: decoded.aluOp = aluAnd;
                    fnOr: decoded.aluOp = aluOr;
                    fnXor: decoded.aluOp = aluXor;
                    fnNor: decoded.aluOp = aluNor;
                    fnSlt: decoded.aluOp = aluSlt;
                    fnSltu: decoded.aluOp = aluSltu;
                    fnSll: decoded.aluOp = aluSll;
                    fnSrl: decoded.aluOp = aluSrl;
                    fnSra: decoded.aluOp = aluSra;
                    default: decoded.aluOp = aluNone;
                endcase
                if (funct inside {fnSll, fnSrl, fnSra}) begin
                    // Shifts take rt as the value and shamt as the amount
                    decoded.src1 = rt;
                    decoded.useImm = 1'b1;
                    decoded.immediate = {27'b0, shamt};
                end
            end
            opAddiu, opSlti, opSltiu: begin
                decoded.aluOp = (opcode == opAddiu) ? aluAdd :
                                (opcode == opSlti) ? aluSlt : aluSltu;
                decoded.src1 = rs;
                decoded.dest = rt;
                decoded.useImm = 1'b1;
                decoded.immediate = signExt;
            end
            opAndi, opOri, opXori, opLui: begin
                decoded.aluOp = (opcode == opAndi) ? aluAnd :
                                (opcode == opOri) ? aluOr :
                                (opcode == opXori) ? aluXor : aluLui;
                decoded.src1 = (opcode == opLui) ? '0 : rs;
                decoded.dest = rt;
                decoded.useImm = 1'b1;
                decoded.immediate = zeroExt;
            end
            default: decoded.aluOp = aluNone;
        endcase
        if (decoded.aluOp == aluNone) begin
            decoded.dest = '0;
        end
    end

endmodule

//--- hdl/cpuPkg.sv
package cpuPkg;

    typedef logic [4:0] regAddrT;
    typedef logic [31:0] wordT;

    // Primary opcode field
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opSlti = 6'h0A;
    localparam logic [5:0] opSltiu = 6'h0B;
    localparam logic [5:0] opAndi = 6'h0C;
    localparam logic [5:0] opOri = 6'h0D;
    localparam logic [5:0] opXori = 6'h0E;
    localparam logic [5:0] opLui = 6'h0F;

    // Function field of SPECIAL
    localparam logic [5:0] fnSll = 6'h00;
    localparam logic [5:0] fnSrl = 6'h02;
    localparam logic [5:0] fnSra = 6'h03;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnXor = 6'h26;
    localparam logic [5:0] fnNor = 6'h27;
    localparam logic [5:0] fnSlt = 6'h2A;
    localparam logic [5:0] fnSltu = 6'h2B;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor, aluSlt, aluSltu,
        aluSll, aluSrl, aluSra,
        aluLui,
        aluNone
    } aluOpT;

    typedef struct packed {
        aluOpT aluOp;
        logic useImm;
        wordT immediate;
        regAddrT src1;
        regAddrT src2;
        regAddrT dest;
    } decodedT;

    // Operands are final here, execute only computes
    typedef struct packed {
        aluOpT aluOp;
        wordT operandA;
        wordT operandB;
        regAddrT dest;
    } issueT;

    typedef struct packed {
        logic valid;
        regAddrT num;
        wordT data;
    } regWriteT;

endpackage
